// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  typedef logic [7:0] word_t;    // Data, address or instruction byte
  typedef logic [2:0] reg_idx_t;
  typedef logic [2:0] alu_op_t;
  typedef logic [1:0] wr_src_t;  // Register write data select

  localparam wr_src_t WR_SRC_REG = 2'd0;
  localparam wr_src_t WR_SRC_ALU = 2'd1;
  localparam wr_src_t WR_SRC_MEM = 2'd2;

  localparam int       NUM_REGS = 8;
  localparam reg_idx_t REG_A    = 3'd0;  // Accumulator
  localparam reg_idx_t REG_B    = 3'd1;
  localparam word_t    RESET_PC = 8'h00;

  // ------------------------------------------------
  // Instruction encodings
  // ------------------------------------------------
  localparam word_t OP_NOP = 8'b00_000_000;
  localparam word_t OP_OUT = 8'b00_000_011;
  localparam word_t OP_HLT = 8'b00_000_101;
  localparam word_t OP_CMP = 8'b00_000_110;
  localparam word_t OP_LDI = 8'b00_010_000;  // Low bits hold target register
  localparam word_t OP_JMP = 8'b00_011_000;  // Low bits hold condition
  localparam word_t OP_ALU = 8'b01_000_000;  // Bits 5:3 hold the operation
  localparam word_t OP_MOV = 8'b10_000_000;  // Destination 5:3, source 2:0

  localparam logic [2:0] JMP_JMP = 3'd0;
  localparam logic [2:0] JMP_JZ  = 3'd1;
  localparam logic [2:0] JMP_JNZ = 3'd2;
  localparam logic [2:0] JMP_JC  = 3'd3;
  localparam logic [2:0] JMP_JNC = 3'd4;

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_INC = 3'd2;
  localparam alu_op_t ALU_DEC = 3'd3;
  localparam alu_op_t ALU_AND = 3'd4;
  localparam alu_op_t ALU_OR  = 3'd5;
  localparam alu_op_t ALU_XOR = 3'd6;
  localparam alu_op_t ALU_ADC = 3'd7;

endpackage

`default_nettype wire

// File: hdl/cpu_ctrl_if.sv
`default_nettype none

interface cpu_ctrl_if (
  input logic clk
);

  logic              wr_en;
  cpu_pkg::reg_idx_t wr_sel;
  cpu_pkg::reg_idx_t rd_sel;   // MOV source
  cpu_pkg::wr_src_t  wr_src;
  cpu_pkg::alu_op_t  alu_op;
  logic              flag_en;  // Load flags from the ALU
  logic              flag_zero;
  logic              flag_carry;

  // Sequencer side
  modport seq (
    input  clk, flag_zero, flag_carry,
    output wr_en, wr_sel, rd_sel, wr_src, alu_op, flag_en
  );

  // Datapath side
  modport dp (
    input  clk, wr_en, wr_sel, rd_sel, wr_src, alu_op, flag_en,
    output flag_zero, flag_carry
  );

endinterface

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              reset,
  input  logic              wr_en,
  input  cpu_pkg::reg_idx_t wr_sel,
  input  cpu_pkg::word_t    wr_data,
  input  cpu_pkg::reg_idx_t rd_sel,
  output cpu_pkg::word_t    rd_data,
  output cpu_pkg::word_t    a_data,
  output cpu_pkg::word_t    b_data
);

  cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_sel] <= wr_data;
    end
  end

  // Read ports are combinational
  assign rd_data = regs[rd_sel];
  assign a_data  = regs[cpu_pkg::REG_A];  // Fixed ALU operands
  assign b_data  = regs[cpu_pkg::REG_B];

endmodule

`default_nettype wire

// File: hdl/alu.sv
`default_nettype none

module alu (
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  cpu_pkg::alu_op_t op,
  input  logic             carry_in,
  output cpu_pkg::word_t   result,
  output logic             zero,
  output logic             carry
);

  logic [8:0] sum;  // Ninth bit is carry or borrow

  always_comb begin
    sum    = '0;
    result = '0;
    carry  = 1'b0;
    case (op)
      cpu_pkg::ALU_ADD: begin
        sum    = {1'b0, a} + {1'b0, b};
        result = sum[7:0];
        carry  = sum[8];
      end
      cpu_pkg::ALU_ADC: begin
        sum    = {1'b0, a} + {1'b0, b} + {8'h00, carry_in};
        result = sum[7:0];
        carry  = sum[8];
      end
      cpu_pkg::ALU_SUB: begin
        sum    = {1'b0, a} - {1'b0, b};
        result = sum[7:0];
        carry  = sum[8];  // Borrow, set when a < b
      end
      cpu_pkg::ALU_INC: begin
        result = a + 8'd1;
        carry  = (a == 8'hFF);
      end
      cpu_pkg::ALU_DEC: begin
        result = a - 8'd1;
        carry  = (a == 8'h00);
      end
      cpu_pkg::ALU_AND: result = a & b;
      cpu_pkg::ALU_OR:  result = a | b;
      cpu_pkg::ALU_XOR: result = a ^ b;
      default:          result = a;
    endcase
  end

  assign zero = (result == 8'h00);

endmodule

`default_nettype wire

// File: hdl/cpu_datapath.sv
`default_nettype none

module cpu_datapath (
  input  logic           clk,
  input  logic           reset,
  cpu_ctrl_if.dp         ctrl,
  input  cpu_pkg::word_t mem_rdata,
  output cpu_pkg::word_t acc
);

  cpu_pkg::word_t wr_data;
  cpu_pkg::word_t rd_data;
  cpu_pkg::word_t a_data;
  cpu_pkg::word_t b_data;
  cpu_pkg::word_t alu_result;
  logic           alu_zero;
  logic           alu_carry;
  logic           zero_q;
  logic           carry_q;

  reg_file u_reg_file (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (ctrl.wr_en),
    .wr_sel  (ctrl.wr_sel),
    .wr_data (wr_data),
    .rd_sel  (ctrl.rd_sel),
    .rd_data (rd_data),
    .a_data  (a_data),
    .b_data  (b_data)
  );

  alu u_alu (
    .a        (a_data),
    .b        (b_data),
    .op       (ctrl.alu_op),
    .carry_in (carry_q),  // For ADC
    .result   (alu_result),
    .zero     (alu_zero),
    .carry    (alu_carry)
  );

  // ------------------------------------------------
  // Write-back select and flags
  // ------------------------------------------------
  always_comb begin
    case (ctrl.wr_src)
      cpu_pkg::WR_SRC_ALU: wr_data = alu_result;
      cpu_pkg::WR_SRC_MEM: wr_data = mem_rdata;  // LDI operand
      default:             wr_data = rd_data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      zero_q  <= 1'b0;
      carry_q <= 1'b0;
    end else if (ctrl.flag_en) begin
      zero_q  <= alu_zero;
      carry_q <= alu_carry;
    end
  end

  assign ctrl.flag_zero  = zero_q;
  assign ctrl.flag_carry = carry_q;
  assign acc             = a_data;

  // Flags only move with an ALU write-back or a CMP
  a_flag_src: assert property (@(posedge clk) disable iff (reset)
    ctrl.flag_en |-> (!ctrl.wr_en || ctrl.wr_src == cpu_pkg::WR_SRC_ALU));

endmodule

`default_nettype wire

// File: hdl/cpu_sequencer.sv
`default_nettype none

module cpu_sequencer (
  input  logic           clk,
  input  logic           reset,
  input  logic           mem_rvalid,
  input  cpu_pkg::word_t mem_rdata,
  output logic           mem_rd,
  output cpu_pkg::word_t mem_addr,
  output logic           out_valid,
  output logic           halted,
  cpu_ctrl_if.seq        ctrl
);

  typedef enum logic [2:0] {
    FETCH_REQ,
    FETCH_WAIT,
    EXECUTE,
    OPERAND_REQ,
    OPERAND_WAIT,
    HALTED
  } state_t;

  state_t         state;
  state_t         state_next;
  cpu_pkg::word_t pc;
  cpu_pkg::word_t ir;
  logic           is_mov;
  logic           is_alu;
  logic           is_ldi;
  logic           is_jmp;
  logic           jump_taken;
  logic           rd_pending;

  // ------------------------------------------------
  // Decode
  // ------------------------------------------------
  assign is_mov = (ir[7:6] == cpu_pkg::OP_MOV[7:6]);
  assign is_alu = (ir[7:6] == cpu_pkg::OP_ALU[7:6]);
  assign is_ldi = (ir[7:3] == cpu_pkg::OP_LDI[7:3]);
  assign is_jmp = (ir[7:3] == cpu_pkg::OP_JMP[7:3]);

  always_comb begin
    case (ir[2:0])
      cpu_pkg::JMP_JMP: jump_taken = 1'b1;
      cpu_pkg::JMP_JZ:  jump_taken = ctrl.flag_zero;
      cpu_pkg::JMP_JNZ: jump_taken = !ctrl.flag_zero;
      cpu_pkg::JMP_JC:  jump_taken = ctrl.flag_carry;
      cpu_pkg::JMP_JNC: jump_taken = !ctrl.flag_carry;
      default:          jump_taken = 1'b0;  // Reserved conditions
    endcase
  end

  // ------------------------------------------------
  // FSM and control outputs
  // ------------------------------------------------
  always_comb begin
    state_next   = state;
    out_valid    = 1'b0;
    ctrl.wr_en   = 1'b0;
    ctrl.wr_sel  = ir[5:3];
    ctrl.rd_sel  = ir[2:0];
    ctrl.wr_src  = cpu_pkg::WR_SRC_REG;
    ctrl.alu_op  = ir[5:3];
    ctrl.flag_en = 1'b0;
    case (state)
      FETCH_REQ:  state_next = FETCH_WAIT;
      FETCH_WAIT: if (mem_rvalid) state_next = EXECUTE;
      EXECUTE: begin
        state_next = FETCH_REQ;
        if (is_mov) begin
          ctrl.wr_en = 1'b1;
        end else if (is_alu) begin
          ctrl.wr_en   = 1'b1;
          ctrl.wr_sel  = cpu_pkg::REG_A;
          ctrl.wr_src  = cpu_pkg::WR_SRC_ALU;
          ctrl.flag_en = 1'b1;
        end else if (is_ldi || is_jmp) begin
          state_next = OPERAND_REQ;  // Needs the second byte
        end else begin
          case (ir)
            cpu_pkg::OP_OUT: out_valid = 1'b1;
            cpu_pkg::OP_HLT: state_next = HALTED;
            cpu_pkg::OP_CMP: begin
              ctrl.alu_op  = cpu_pkg::ALU_SUB;
              ctrl.flag_en = 1'b1;  // Flags only, no write
            end
            default: ;  // NOP and unknown opcodes
          endcase
        end
      end
      OPERAND_REQ: state_next = OPERAND_WAIT;
      OPERAND_WAIT: begin
        if (mem_rvalid) begin
          state_next = FETCH_REQ;
          if (is_ldi) begin
            ctrl.wr_en  = 1'b1;
            ctrl.wr_sel = ir[2:0];
            ctrl.wr_src = cpu_pkg::WR_SRC_MEM;
          end
        end
      end
      HALTED:  state_next = HALTED;  // Left only by reset
      default: state_next = FETCH_REQ;
    endcase
  end

  assign mem_rd   = (state == FETCH_REQ) || (state == OPERAND_REQ);
  assign mem_addr = pc;
  assign halted   = (state == HALTED);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FETCH_REQ;
      pc    <= cpu_pkg::RESET_PC;
      ir    <= cpu_pkg::OP_NOP;
    end else begin
      state <= state_next;
      if (state == FETCH_WAIT && mem_rvalid) begin
        ir <= mem_rdata;
        pc <= pc + 8'd1;
      end
      if (state == OPERAND_WAIT && mem_rvalid) begin
        pc <= (is_jmp && jump_taken) ? mem_rdata : pc + 8'd1;
      end
    end
  end

  // Outstanding read tracker, checked against the memory port
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pending <= 1'b0;
    end else if (mem_rd) begin
      rd_pending <= 1'b1;
    end else if (mem_rvalid) begin
      rd_pending <= 1'b0;
    end
  end

  a_one_read: assert property (@(posedge clk) disable iff (reset)
    mem_rd |-> !rd_pending);

  a_out_no_rd: assert property (@(posedge clk) disable iff (reset)
    !(out_valid && mem_rd));

  a_halt_sticky: assert property (@(posedge clk)
    (halted && !reset) |=> halted);

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
`default_nettype none

module cpu_top (
  input  logic       clk,
  input  logic       reset,
  input  logic       mem_rvalid,
  input  logic [7:0] mem_rdata,
  output logic       mem_rd,
  output logic [7:0] mem_addr,
  output logic       out_valid,
  output logic [7:0] out_data,   // Mirrors the accumulator
  output logic       halted
);

  cpu_ctrl_if ctrl_bus (.clk(clk));

  // ------------------------------------------------
  // Control and datapath
  // ------------------------------------------------
  cpu_sequencer u_sequencer (
    .clk        (clk),
    .reset      (reset),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .mem_rd     (mem_rd),
    .mem_addr   (mem_addr),
    .out_valid  (out_valid),
    .halted     (halted),
    .ctrl       (ctrl_bus.seq)
  );

  cpu_datapath u_datapath (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl_bus.dp),
    .mem_rdata (mem_rdata),  // LDI operand path
    .acc       (out_data)
  );

endmodule

`default_nettype wire

// File: verification/cpu_tb_tests.svh
`default_nettype none

// --------------------------------------------------
// Program assembly
// --------------------------------------------------
task automatic clear_program();
  for (int i = 0; i < 256; i++) begin
    mem[i] = cpu_pkg::word_t'(i * 7) ^ 8'hA5;  // Address-dependent fill
  end
  load_addr = '0;
  expected.delete();
endtask

task automatic put_byte(input cpu_pkg::word_t b);
  mem[load_addr] = b;
  load_addr++;
endtask

task automatic load_imm(input cpu_pkg::reg_idx_t r, input cpu_pkg::word_t value);
  put_byte(cpu_pkg::OP_LDI | {5'b0, r});
  put_byte(value);
endtask

task automatic move_reg(input cpu_pkg::reg_idx_t dst, input cpu_pkg::reg_idx_t src);
  put_byte(cpu_pkg::OP_MOV | {2'b00, dst, src});
endtask

task automatic alu_instr(input cpu_pkg::alu_op_t op);
  put_byte(cpu_pkg::OP_ALU | {2'b00, op, 3'b000});
endtask

task automatic jump_to(input logic [2:0] cond, input cpu_pkg::word_t target);
  put_byte(cpu_pkg::OP_JMP | {5'b0, cond});
  put_byte(target);
endtask

// Loads A and B, runs one operation and outputs A
task automatic alu_case(input cpu_pkg::alu_op_t op, input cpu_pkg::word_t a,
                        input cpu_pkg::word_t b, input cpu_pkg::word_t result);
  load_imm(cpu_pkg::REG_A, a);
  load_imm(cpu_pkg::REG_B, b);
  alu_instr(op);
  put_byte(cpu_pkg::OP_OUT);
  expected.push_back(result);
endtask

// --------------------------------------------------
// Directed tests
// --------------------------------------------------
task automatic ldi_each_reg();
  int err_before;
  err_before = errors;
  clear_program();
  for (int r = 0; r < cpu_pkg::NUM_REGS; r++) begin
    load_imm(cpu_pkg::reg_idx_t'(r), cpu_pkg::word_t'(8'h0F + 8'h21 * r));
  end
  for (int r = 0; r < cpu_pkg::NUM_REGS; r++) begin
    move_reg(cpu_pkg::REG_A, cpu_pkg::reg_idx_t'(r));
    put_byte(cpu_pkg::OP_OUT);
    expected.push_back(cpu_pkg::word_t'(8'h0F + 8'h21 * r));
  end
  put_byte(cpu_pkg::OP_HLT);
  run_to_halt("ldi_each_reg");
  check_outputs("ldi_each_reg");
  report_test("ldi_each_reg", err_before);
endtask

task automatic mov_chains();
  int err_before;
  err_before = errors;
  clear_program();
  load_imm(cpu_pkg::REG_A, 8'h5A);
  move_reg(cpu_pkg::REG_B, cpu_pkg::REG_A);
  move_reg(3'd2, cpu_pkg::REG_B);
  load_imm(cpu_pkg::REG_A, 8'h00);
  move_reg(cpu_pkg::REG_A, 3'd2);  // Back to A through C
  put_byte(cpu_pkg::OP_OUT);
  load_imm(3'd6, 8'hC3);
  move_reg(3'd6, 3'd6);
  move_reg(cpu_pkg::REG_A, cpu_pkg::REG_A);
  put_byte(cpu_pkg::OP_OUT);
  move_reg(cpu_pkg::REG_A, 3'd6);
  put_byte(cpu_pkg::OP_OUT);
  move_reg(cpu_pkg::REG_A, cpu_pkg::REG_B);
  put_byte(cpu_pkg::OP_OUT);
  put_byte(cpu_pkg::OP_HLT);
  expected = '{8'h5A, 8'h5A, 8'hC3, 8'h5A};
  run_to_halt("mov_chains");
  check_outputs("mov_chains");
  report_test("mov_chains", err_before);
endtask

task automatic alu_ops();
  int err_before;
  err_before = errors;
  clear_program();
  alu_case(cpu_pkg::ALU_ADD, 8'hFF, 8'h01, 8'h00);  // Carry out set
  alu_case(cpu_pkg::ALU_ADC, 8'h10, 8'h20, 8'h31);
  alu_case(cpu_pkg::ALU_ADC, 8'h10, 8'h20, 8'h30);  // Previous ADC left carry clear
  alu_case(cpu_pkg::ALU_SUB, 8'h50, 8'h30, 8'h20);
  alu_case(cpu_pkg::ALU_SUB, 8'h30, 8'h50, 8'hE0);  // Borrow
  alu_case(cpu_pkg::ALU_ADC, 8'h01, 8'h01, 8'h03);
  alu_case(cpu_pkg::ALU_INC, 8'hFF, 8'h5E, 8'h00);
  alu_case(cpu_pkg::ALU_ADC, 8'h00, 8'h00, 8'h01);
  alu_case(cpu_pkg::ALU_DEC, 8'h00, 8'h77, 8'hFF);
  alu_case(cpu_pkg::ALU_ADC, 8'h00, 8'h00, 8'h01);  // Carry from DEC of 00
  alu_case(cpu_pkg::ALU_SUB, 8'h00, 8'h01, 8'hFF);
  alu_case(cpu_pkg::ALU_AND, 8'h3C, 8'h0F, 8'h0C);
  alu_case(cpu_pkg::ALU_ADC, 8'h00, 8'h00, 8'h00);
  alu_case(cpu_pkg::ALU_ADD, 8'hFF, 8'hFF, 8'hFE);
  alu_case(cpu_pkg::ALU_OR,  8'h3C, 8'h0F, 8'h3F);
  alu_case(cpu_pkg::ALU_ADC, 8'h00, 8'h00, 8'h00);
  alu_case(cpu_pkg::ALU_DEC, 8'h00, 8'h00, 8'hFF);
  alu_case(cpu_pkg::ALU_XOR, 8'h3C, 8'h0F, 8'h33);
  alu_case(cpu_pkg::ALU_ADC, 8'h80, 8'h80, 8'h00);  // Logic op cleared carry
  alu_case(cpu_pkg::ALU_ADC, 8'h01, 8'h02, 8'h04);
  put_byte(cpu_pkg::OP_HLT);
  run_to_halt("alu_ops");
  check_outputs("alu_ops");
  report_test("alu_ops", err_before);
endtask

task automatic cmp_jumps();
  int             err_before;
  cpu_pkg::word_t a;
  cpu_pkg::word_t b;
  logic           zero;
  logic           carry;
  logic           taken;
  logic [2:0]     cond;
  err_before = errors;
  clear_program();
  for (int rel = 0; rel < 3; rel++) begin  // Equal, smaller B, larger B
    for (int c = 0; c < 5; c++) begin
      a = cpu_pkg::word_t'(8'h40 + rel * 5 + c);
      b = (rel == 0) ? a : (rel == 1) ? a - 8'd5 : a + 8'd9;
      zero  = (a == b);
      carry = (a < b);
      case (c)
        0:       cond = cpu_pkg::JMP_JZ;
        1:       cond = cpu_pkg::JMP_JNZ;
        2:       cond = cpu_pkg::JMP_JC;
        3:       cond = cpu_pkg::JMP_JNC;
        default: cond = cpu_pkg::JMP_JMP;
      endcase
      case (c)
        0:       taken = zero;
        1:       taken = !zero;
        2:       taken = carry;
        3:       taken = !carry;
        default: taken = 1'b1;
      endcase
      load_imm(cpu_pkg::REG_A, a);
      load_imm(cpu_pkg::REG_B, b);
      put_byte(cpu_pkg::OP_CMP);
      jump_to(cond, load_addr + 8'd3);  // Lands just past the OUT
      put_byte(cpu_pkg::OP_OUT);
      if (!taken) begin
        expected.push_back(a);
      end
    end
  end
  put_byte(cpu_pkg::OP_HLT);
  run_to_halt("cmp_jumps");
  check_outputs("cmp_jumps");
  report_test("cmp_jumps", err_before);
endtask

task automatic halt_and_rerun();
  int err_before;
  err_before = errors;
  clear_program();
  load_imm(cpu_pkg::REG_A, 8'h77);
  put_byte(cpu_pkg::OP_OUT);
  alu_instr(cpu_pkg::ALU_INC);
  put_byte(cpu_pkg::OP_OUT);
  put_byte(cpu_pkg::OP_HLT);
  expected = '{8'h77, 8'h78};
  run_to_halt("halt_and_rerun");
  check_outputs("halt_and_rerun");
  for (int i = 0; i < 50; i++) begin  // Idle window after HLT
    @(negedge clk);
    if (!halted) begin
      $display("halt_and_rerun: halted dropped without reset");
      errors++;
    end
    if (mem_rd || out_valid) begin
      $display("halt_and_rerun: bus activity seen while halted");
      errors++;
    end
  end
  seen.delete();
  apply_reset();
  if (halted) begin
    $display("halt_and_rerun: reset did not clear halted");
    errors++;
  end
  if (mem_addr != 8'h00) begin  // First fetch after reset
    $display("CHECK FAILED halt_and_rerun mem_addr: expected %h, actual %h",
             8'h00, mem_addr);
    errors++;
  end
  wait_halt("halt_and_rerun");
  check_outputs("halt_and_rerun");
  report_test("halt_and_rerun", err_before);
endtask

`default_nettype wire

// File: verification/cpu_tb.sv
`default_nettype none

module cpu_tb;

  localparam int NUM_TESTS  = 5;
  localparam int MAX_CYCLES = 64 * 12;  // Per program run

  logic           clk;
  logic           reset      = 1'b1;
  logic           mem_rvalid = 1'b0;
  cpu_pkg::word_t mem_rdata  = '0;
  logic           mem_rd;
  cpu_pkg::word_t mem_addr;
  logic           out_valid;
  cpu_pkg::word_t out_data;
  logic           halted;

  cpu_pkg::word_t mem [256];
  cpu_pkg::word_t load_addr;     // Next free program byte
  cpu_pkg::word_t seen [$];      // out_data taken while out_valid
  cpu_pkg::word_t expected [$];
  cpu_pkg::word_t lfsr       = 8'd8;
  cpu_pkg::word_t rd_addr;
  logic [1:0]     delay;
  int             rd_delay;
  logic           rd_pending = 1'b0;
  int             errors     = 0;
  int             passed     = 0;
  int             failed     = 0;

  cpu_top DUT (
    .clk        (clk),
    .reset      (reset),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .mem_rd     (mem_rd),
    .mem_addr   (mem_addr),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .halted     (halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Taps 8, 6, 5, 4
  function automatic cpu_pkg::word_t lfsr_next(input cpu_pkg::word_t s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // --------------------------------------------------
  // Memory model answering after 1 to 4 cycles
  // --------------------------------------------------
  always @(negedge clk) begin
    mem_rvalid <= 1'b0;
    if (rd_pending) begin
      if (rd_delay == 1) begin
        mem_rvalid <= 1'b1;
        mem_rdata  <= mem[rd_addr];
        rd_pending <= 1'b0;
      end
      rd_delay <= rd_delay - 1;
    end
    if (mem_rd) begin  // A new request replaces any older one
      lfsr       = lfsr_next(lfsr);
      delay[0]   = lfsr[0];
      lfsr       = lfsr_next(lfsr);
      delay[1]   = lfsr[0];
      rd_addr    <= mem_addr;
      rd_delay   <= int'(delay) + 1;
      rd_pending <= 1'b1;
    end
  end

  initial begin
    #(NUM_TESTS * 64 * 12 * 10);
    $display("Watchdog expired before all tests finished");
    $display("Test failed");
    $finish;
  end

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (5) @(negedge clk);
    reset = 1'b0;
  endtask

  // Collects outputs until halted or the cycle limit
  task automatic wait_halt(input string name);
    int cycles;
    cycles = 0;
    while (!halted && cycles < MAX_CYCLES) begin
      @(negedge clk);
      if (out_valid) begin
        seen.push_back(out_data);
      end
      cycles++;
    end
    if (!halted) begin
      $display("%s: program did not halt within %0d cycles", name, MAX_CYCLES);
      errors++;
    end
  endtask

  task automatic run_to_halt(input string name);
    seen.delete();
    apply_reset();
    wait_halt(name);
  endtask

  task automatic check_outputs(input string name);
    if (seen.size() != expected.size()) begin
      $display("%s: expected %0d outputs but saw %0d", name, expected.size(), seen.size());
      errors++;
    end
    for (int i = 0; i < seen.size() && i < expected.size(); i++) begin
      if (seen[i] != expected[i]) begin
        $display("CHECK FAILED %s out_data[%0d]: expected %h, actual %h",
                 name, i, expected[i], seen[i]);
        errors++;
      end
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      passed++;
      $display("%s: PASS", name);
    end else begin
      failed++;
      $display("%s: FAIL with %0d errors", name, errors - err_before);
    end
  endtask

  initial begin
    ldi_each_reg();
    mov_chains();
    alu_ops();
    cmp_jumps();
    halt_and_rerun();
    $display("Tests passed: %0d, failed: %0d", passed, failed);
    if (failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

`include "cpu_tb_tests.svh"

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verification
hdl/cpu_pkg.sv
hdl/cpu_ctrl_if.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/cpu_datapath.sv
hdl/cpu_sequencer.sv
hdl/cpu_top.sv
verification/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module cpu_tb -f filelist.f -o cpu_sim \
  && ./obj_dir/cpu_sim | tee /dev/stderr | grep -q "Test completed successfully" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
